//--- source/tpl_adc_pkg.sv
`default_nettype none

package tpl_adc_pkg;

  // ******************************************************************
  // register bus
  // ******************************************************************

  // one host request, at most one strobe high per cycle
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [11:0] addr;
    logic [31:0] wdata;
  } up_req_t;

  // response, rdata only meaningful while ack is high
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } up_rsp_t;

  localparam logic [31:0] CORE_VERSION = 32'h0001_0061;

  // ******************************************************************
  // common register offsets
  // ******************************************************************

  localparam logic [11:0] REG_VERSION = 12'h000;
  localparam logic [11:0] REG_ID      = 12'h001;
  localparam logic [11:0] REG_SCRATCH = 12'h002;
  localparam logic [11:0] REG_RSTN    = 12'h010;
  localparam logic [11:0] REG_STATUS  = 12'h017;
  localparam logic [11:0] REG_OVF     = 12'h018;
  localparam logic [11:0] REG_PN_SUM  = 12'h01a;

  // channel peers sit at CHAN_BASE + n * CHAN_STRIDE
  localparam logic [11:0] CHAN_BASE   = 12'h100;
  localparam logic [11:0] CHAN_STRIDE = 12'h010;

  // offsets inside one channel window
  localparam logic [3:0] CH_CTRL      = 4'h0;
  localparam logic [3:0] CH_PN_STATUS = 4'h1;
  localparam logic [3:0] CH_PN_SEL    = 4'h2;

  // ******************************************************************
  // PN monitor
  // ******************************************************************

  // any other code turns the checker off
  localparam logic [3:0] PN_MODE_PN9  = 4'd0;
  localparam logic [3:0] PN_MODE_PN15 = 4'd1;

  // consecutive samples needed to enter or leave sync
  localparam int PN_SYNC_COUNT = 16;

  localparam int SAMPLE_W = 16;

endpackage

`default_nettype wire

//--- source/up_bus_merge.sv
`timescale 1ns/1ps
`default_nettype none

module up_bus_merge
  import tpl_adc_pkg::*;
#(
  parameter int NUM_CHANNELS = 1
) (
  input  wire                             link_clk,
  input  wire                             adc_rst,
  input  wire up_req_t                    host_req,
  output up_rsp_t                         host_rsp,
  output up_req_t                         bus_req,
  input  wire [(NUM_CHANNELS+1)*32-1:0]   peer_rdata
);

  localparam int NUM_PEERS = NUM_CHANNELS + 1;

  logic        ack_q;
  logic [31:0] rdata_or;

  // ******************************************************************
  // request pipeline
  // ******************************************************************

  // request strobes
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      bus_req.wr <= 1'b0;
      bus_req.rd <= 1'b0;
    end else begin
      bus_req.wr <= host_req.wr;
      bus_req.rd <= host_req.rd;
    end
  end

  // address and write data
  always_ff @(posedge link_clk) begin
    bus_req.addr  <= host_req.addr;
    bus_req.wdata <= host_req.wdata;
  end

  // second strobe stage lines up with peer rdata
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req.wr | bus_req.rd;
    end
  end

  // ******************************************************************
  // response merge
  // ******************************************************************

  // unaddressed peers hold zero rdata
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i < NUM_PEERS; i++) begin
      rdata_or = rdata_or | peer_rdata[i*32 +: 32];
    end
  end

  assign host_rsp.ack   = ack_q;
  assign host_rsp.rdata = rdata_or;

endmodule

`default_nettype wire

//--- source/up_adc_common_regs.sv
`timescale 1ns/1ps
`default_nettype none

module up_adc_common_regs
  import tpl_adc_pkg::*;
#(
  parameter int          NUM_CHANNELS = 1,
  parameter logic [31:0] ID           = 32'h0
) (
  input  wire                    link_clk,
  input  wire                    adc_rst,
  input  wire up_req_t           bus_req,
  output logic [31:0]            rdata,
  input  wire                    adc_dovf,
  input  wire [NUM_CHANNELS-1:0] pn_err,
  input  wire [NUM_CHANNELS-1:0] pn_oos,
  output logic                   core_rst
);

  logic [31:0] scratch;
  logic        core_rstn;
  logic        status_q;
  logic        ovf_sticky;
  logic        pn_err_sticky;
  logic        pn_oos_any;
  logic [31:0] rdata_mux;

  logic wr_scratch;
  logic wr_rstn;
  logic wr_ovf;
  logic wr_pn_sum;

  // ******************************************************************
  // write decode
  // ******************************************************************

  assign wr_scratch = bus_req.wr && (bus_req.addr == REG_SCRATCH);
  assign wr_rstn    = bus_req.wr && (bus_req.addr == REG_RSTN);
  assign wr_ovf     = bus_req.wr && (bus_req.addr == REG_OVF);
  assign wr_pn_sum  = bus_req.wr && (bus_req.addr == REG_PN_SUM);

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      scratch   <= '0;
      core_rstn <= 1'b0;
    end else begin
      if (wr_scratch) begin
        scratch <= bus_req.wdata;
      end
      if (wr_rstn) begin
        core_rstn <= bus_req.wdata[0];
      end
    end
  end

  assign core_rst = ~core_rstn;

  // ******************************************************************
  // status and sticky flags
  // ******************************************************************

  // a new event wins over a same-cycle clear
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      status_q      <= 1'b0;
      ovf_sticky    <= 1'b0;
      pn_err_sticky <= 1'b0;
    end else begin
      status_q <= ~core_rst;
      if (adc_dovf) begin
        ovf_sticky <= 1'b1;
      end else if (wr_ovf && bus_req.wdata[0]) begin
        ovf_sticky <= 1'b0;
      end
      if (|pn_err) begin
        pn_err_sticky <= 1'b1;
      end else if (wr_pn_sum && bus_req.wdata[0]) begin
        pn_err_sticky <= 1'b0;
      end
    end
  end

  assign pn_oos_any = |pn_oos;

  // read mux, unmapped offsets fall through to zero
  always_comb begin
    case (bus_req.addr)
      REG_VERSION: rdata_mux = CORE_VERSION;
      REG_ID:      rdata_mux = ID;
      REG_SCRATCH: rdata_mux = scratch;
      REG_RSTN:    rdata_mux = {31'd0, core_rstn};
      REG_STATUS:  rdata_mux = {31'd0, status_q};
      REG_OVF:     rdata_mux = {31'd0, ovf_sticky};
      REG_PN_SUM:  rdata_mux = {30'd0, pn_oos_any, pn_err_sticky};
      default:     rdata_mux = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      rdata <= '0;
    end else begin
      rdata <= bus_req.rd ? rdata_mux : 32'd0;
    end
  end

endmodule

`default_nettype wire

//--- source/up_adc_channel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module up_adc_channel_regs
  import tpl_adc_pkg::*;
#(
  parameter int CHANNEL_ID = 0
) (
  input  wire          link_clk,
  input  wire          adc_rst,
  input  wire up_req_t bus_req,
  output logic [31:0]  rdata,
  output logic         enable,
  output logic         dfmt_enable,
  output logic         dfmt_sign_extend,
  output logic         dfmt_type,
  output logic [3:0]   pn_seq_sel,
  input  wire          pn_err,
  input  wire          pn_oos
);

  // base address of this channel window
  localparam logic [11:0] BASE = 12'(CHAN_BASE + CHANNEL_ID * CHAN_STRIDE);

  logic        hit;
  logic [3:0]  offset;
  logic        wr_ctrl;
  logic        wr_pn_status;
  logic        wr_pn_sel;
  logic        pn_err_sticky;
  logic [31:0] rdata_mux;

  // ******************************************************************
  // address decode
  // ******************************************************************

  assign hit    = (bus_req.addr[11:4] == BASE[11:4]);
  assign offset = bus_req.addr[3:0];

  assign wr_ctrl      = bus_req.wr && hit && (offset == CH_CTRL);
  assign wr_pn_status = bus_req.wr && hit && (offset == CH_PN_STATUS);
  assign wr_pn_sel    = bus_req.wr && hit && (offset == CH_PN_SEL);

  // ******************************************************************
  // control registers
  // ******************************************************************

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      enable           <= 1'b0;
      dfmt_type        <= 1'b0;
      dfmt_enable      <= 1'b0;
      dfmt_sign_extend <= 1'b0;
      pn_seq_sel       <= '0;
    end else begin
      if (wr_ctrl) begin
        enable           <= bus_req.wdata[0];
        dfmt_type        <= bus_req.wdata[2];
        dfmt_enable      <= bus_req.wdata[4];
        dfmt_sign_extend <= bus_req.wdata[6];
      end
      if (wr_pn_sel) begin
        pn_seq_sel <= bus_req.wdata[3:0];
      end
    end
  end

  // sticky pn error, set has priority over W1C
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      pn_err_sticky <= 1'b0;
    end else if (pn_err) begin
      pn_err_sticky <= 1'b1;
    end else if (wr_pn_status && bus_req.wdata[1]) begin
      pn_err_sticky <= 1'b0;
    end
  end

  // ******************************************************************
  // readback
  // ******************************************************************

  always_comb begin
    rdata_mux = '0;
    case (offset)
      CH_CTRL: begin
        rdata_mux[0] = enable;
        rdata_mux[2] = dfmt_type;
        rdata_mux[4] = dfmt_enable;
        rdata_mux[6] = dfmt_sign_extend;
      end
      CH_PN_STATUS: begin
        rdata_mux[1] = pn_err_sticky;
        rdata_mux[2] = pn_oos;
      end
      CH_PN_SEL: rdata_mux[3:0] = pn_seq_sel;
      default:   rdata_mux = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      rdata <= '0;
    end else begin
      rdata <= (bus_req.rd && hit) ? rdata_mux : 32'd0;
    end
  end

endmodule

`default_nettype wire

//--- source/adc_pn_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module adc_pn_monitor
  import tpl_adc_pkg::*;
(
  input  wire                link_clk,
  input  wire                adc_rst,
  input  wire                core_rst,
  input  wire [3:0]          pn_sel,
  input  wire                adc_valid,
  input  wire [SAMPLE_W-1:0] sample,
  output logic               pn_err,
  output logic               pn_oos
);

  localparam int CNT_W = $clog2(PN_SYNC_COUNT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PN_SYNC_COUNT - 1);

  logic [SAMPLE_W-1:0] prev_sample;
  logic [SAMPLE_W-1:0] predicted;
  logic                mode_pn9;
  logic                mode_pn15;
  logic                active;
  logic                match;
  logic [CNT_W-1:0]    cnt;

  // ******************************************************************
  // sequence prediction
  // ******************************************************************

  // x^9 + x^5 + 1, one new bit per step shifted in at the bottom
  function automatic logic [SAMPLE_W-1:0] pn9_advance(input logic [SAMPLE_W-1:0] prev);
    logic [SAMPLE_W-1:0] d;
    d = prev;
    for (int i = 0; i < SAMPLE_W; i++) begin
      d = {d[SAMPLE_W-2:0], d[8] ^ d[4]};
    end
    return d;
  endfunction

  // x^15 + x^14 + 1
  function automatic logic [SAMPLE_W-1:0] pn15_advance(input logic [SAMPLE_W-1:0] prev);
    logic [SAMPLE_W-1:0] d;
    d = prev;
    for (int i = 0; i < SAMPLE_W; i++) begin
      d = {d[SAMPLE_W-2:0], d[14] ^ d[13]};
    end
    return d;
  endfunction

  assign mode_pn9  = (pn_sel == PN_MODE_PN9);
  assign mode_pn15 = (pn_sel == PN_MODE_PN15);
  assign active    = (mode_pn9 || mode_pn15) && !core_rst;

  assign predicted = mode_pn15 ? pn15_advance(prev_sample) : pn9_advance(prev_sample);

  // an all-zero word would lock the LFSR, never count it as a match
  assign match = (sample == predicted) && (|sample);

  // seed for the next prediction is simply the last received word
  always_ff @(posedge link_clk) begin
    if (adc_valid) begin
      prev_sample <= sample;
    end
  end

  // ******************************************************************
  // sync tracking
  // ******************************************************************

  always_ff @(posedge link_clk) begin
    if (adc_rst || !active) begin
      pn_oos <= 1'b1;
      pn_err <= 1'b0;
      cnt    <= '0;
    end else begin
      pn_err <= 1'b0;
      if (adc_valid) begin
        if (pn_oos) begin
          // count consecutive matches
          if (!match) begin
            cnt <= '0;
          end else if (cnt == CNT_LAST) begin
            pn_oos <= 1'b0;
            cnt    <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end else begin
          // count consecutive misses, no err pulse on the one that drops sync
          if (match) begin
            cnt <= '0;
          end else if (cnt == CNT_LAST) begin
            pn_oos <= 1'b1;
            cnt    <= '0;
          end else begin
            cnt    <= cnt + 1'b1;
            pn_err <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/tpl_adc_regmap.sv
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_regmap
  import tpl_adc_pkg::*;
#(
  parameter int          NUM_CHANNELS = 1,
  parameter logic [31:0] ID           = 32'h0
) (
  input  wire                             link_clk,
  input  wire                             adc_rst,
  input  wire up_req_t                    host_req,
  output up_rsp_t                         host_rsp,
  input  wire [NUM_CHANNELS*SAMPLE_W-1:0] adc_data,
  input  wire                             adc_valid,
  input  wire                             adc_dovf,
  output logic [NUM_CHANNELS-1:0]         enable,
  output logic [NUM_CHANNELS-1:0]         dfmt_enable,
  output logic [NUM_CHANNELS-1:0]         dfmt_sign_extend,
  output logic [NUM_CHANNELS-1:0]         dfmt_type,
  output logic [NUM_CHANNELS*4-1:0]       pn_seq_sel,
  output logic [NUM_CHANNELS-1:0]         pn_err,
  output logic [NUM_CHANNELS-1:0]         pn_oos
);

  up_req_t                       bus_req;
  logic [(NUM_CHANNELS+1)*32-1:0] peer_rdata;
  logic                          core_rst;

  // ******************************************************************
  // bus and common block
  // ******************************************************************

  up_bus_merge #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_up_bus_merge (
    .link_clk   (link_clk),
    .adc_rst    (adc_rst),
    .host_req   (host_req),
    .host_rsp   (host_rsp),
    .bus_req    (bus_req),
    .peer_rdata (peer_rdata)
  );

  // common peer takes slot 0 of the read data
  up_adc_common_regs #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .ID           (ID)
  ) u_up_adc_common_regs (
    .link_clk (link_clk),
    .adc_rst  (adc_rst),
    .bus_req  (bus_req),
    .rdata    (peer_rdata[31:0]),
    .adc_dovf (adc_dovf),
    .pn_err   (pn_err),
    .pn_oos   (pn_oos),
    .core_rst (core_rst)
  );

  // ******************************************************************
  // per channel registers and PN checkers
  // ******************************************************************

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    up_adc_channel_regs #(
      .CHANNEL_ID (i)
    ) u_up_adc_channel_regs (
      .link_clk         (link_clk),
      .adc_rst          (adc_rst),
      .bus_req          (bus_req),
      .rdata            (peer_rdata[(i+1)*32 +: 32]),
      .enable           (enable[i]),
      .dfmt_enable      (dfmt_enable[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .dfmt_type        (dfmt_type[i]),
      .pn_seq_sel       (pn_seq_sel[i*4 +: 4]),
      .pn_err           (pn_err[i]),
      .pn_oos           (pn_oos[i])
    );

    adc_pn_monitor u_adc_pn_monitor (
      .link_clk  (link_clk),
      .adc_rst   (adc_rst),
      .core_rst  (core_rst),
      .pn_sel    (pn_seq_sel[i*4 +: 4]),
      .adc_valid (adc_valid),
      .sample    (adc_data[i*SAMPLE_W +: SAMPLE_W]),
      .pn_err    (pn_err[i]),
      .pn_oos    (pn_oos[i])
    );
  end

endmodule

`default_nettype wire

//--- test/tpl_adc_regmap_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_regmap_sva
  import tpl_adc_pkg::*;
#(
  parameter int NUM_CHANNELS = 1
) (
  input wire                    link_clk,
  input wire                    adc_rst,
  input wire up_req_t           host_req,
  input wire up_rsp_t           host_rsp,
  input wire [NUM_CHANNELS-1:0] pn_err,
  input wire [NUM_CHANNELS-1:0] pn_oos
);

  logic strobe;

  assign strobe = host_req.wr | host_req.rd;

  // ******************************************************************
  // bus timing
  // ******************************************************************

  // every request answered two edges later
  ack_after_strobe: assert property (
    @(posedge link_clk) disable iff (adc_rst) strobe |-> ##2 host_rsp.ack
  ) else $error("acknowledge missing two cycles after a request");

  // no acknowledge without a matching request
  no_stray_ack: assert property (
    @(posedge link_clk) disable iff (adc_rst) host_rsp.ack |-> $past(strobe, 2)
  ) else $error("acknowledge without a request two cycles earlier");

  // ******************************************************************
  // PN status
  // ******************************************************************

  // err pulses only come from a channel in sync
  err_only_in_sync: assert property (
    @(posedge link_clk) disable iff (adc_rst) (pn_err & pn_oos) == '0
  ) else $error("pn_err high on a channel that is out of sync");

endmodule

bind tpl_adc_regmap tpl_adc_regmap_sva #(
  .NUM_CHANNELS (NUM_CHANNELS)
) u_tpl_adc_regmap_sva (
  .link_clk (link_clk),
  .adc_rst  (adc_rst),
  .host_req (host_req),
  .host_rsp (host_rsp),
  .pn_err   (pn_err),
  .pn_oos   (pn_oos)
);

`default_nettype wire

//--- test/tb_tpl_adc_regmap.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tpl_adc_regmap
  import tpl_adc_pkg::*;
();

  localparam int          NUM_CH     = 4;
  localparam logic [31:0] TB_ID      = 32'h0000_005a;
  localparam int          MAX_CYCLES = 3000;
  localparam logic [31:0] LFSR_POLY  = 32'h8020_0003;

  logic                       link_clk;
  logic                       adc_rst;
  up_req_t                    host_req;
  up_rsp_t                    host_rsp;
  logic [NUM_CH*SAMPLE_W-1:0] adc_data;
  logic                       adc_valid;
  logic                       adc_dovf;
  logic [NUM_CH-1:0]          enable;
  logic [NUM_CH-1:0]          dfmt_enable;
  logic [NUM_CH-1:0]          dfmt_sign_extend;
  logic [NUM_CH-1:0]          dfmt_type;
  logic [NUM_CH*4-1:0]        pn_seq_sel;
  logic [NUM_CH-1:0]          pn_err;
  logic [NUM_CH-1:0]          pn_oos;

  logic [31:0]         lfsr_state;
  logic [SAMPLE_W-1:0] pn_word [NUM_CH];
  int                  cycle_cnt = 0;

  tpl_adc_regmap #(
    .NUM_CHANNELS (NUM_CH),
    .ID           (TB_ID)
  ) u_tpl_adc_regmap (
    .link_clk         (link_clk),
    .adc_rst          (adc_rst),
    .host_req         (host_req),
    .host_rsp         (host_rsp),
    .adc_data         (adc_data),
    .adc_valid        (adc_valid),
    .adc_dovf         (adc_dovf),
    .enable           (enable),
    .dfmt_enable      (dfmt_enable),
    .dfmt_sign_extend (dfmt_sign_extend),
    .dfmt_type        (dfmt_type),
    .pn_seq_sel       (pn_seq_sel),
    .pn_err           (pn_err),
    .pn_oos           (pn_oos)
  );

  initial link_clk = 1'b0;
  always #2 link_clk = ~link_clk;

  always @(posedge link_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "run timed out");
    end
  end

  // ******************************************************************
  // helpers
  // ******************************************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // stream s[n] = s[n-9]^s[n-5] or s[n-15]^s[n-14]
  // msb of a word goes first
  function automatic logic [SAMPLE_W-1:0] pn_word_after(input logic [SAMPLE_W-1:0] prev,
                                                        input logic use_pn15);
    logic [2*SAMPLE_W-1:0] s;
    s = {prev, 16'h0000};
    for (int p = SAMPLE_W - 1; p >= 0; p--) begin
      s[p] = use_pn15 ? (s[p+15] ^ s[p+14]) : (s[p+9] ^ s[p+5]);
    end
    return s[SAMPLE_W-1:0];
  endfunction

  function automatic logic [11:0] chan_addr(input int ch, input logic [3:0] off);
    return CHAN_BASE + 12'(ch) * CHAN_STRIDE + {8'd0, off};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERR %s exp %h got %h", name, exp, got);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic require_true(input logic ok, input string what);
    assert (ok) else begin
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // single strobe, then wait for the acknowledge
  task automatic bus_access(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge link_clk);
    host_req.wr    = wr;
    host_req.rd    = !wr;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    @(negedge link_clk);
    host_req.wr = 1'b0;
    host_req.rd = 1'b0;
    while (!host_rsp.ack) begin
      @(negedge link_clk);
    end
    rdata = host_rsp.rdata;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic verify_reg(input string name, input logic [11:0] addr,
                            input logic [31:0] exp);
    logic [31:0] got;
    bus_access(1'b0, addr, 32'h0, got);
    compare_value(name, exp, got);
  endtask

  // one valid beat on all channels
  // channels 2 and 3 carry PN15
  task automatic send_beat(input logic [NUM_CH-1:0] flip_mask,
                           input logic [NUM_CH-1:0] zero_mask);
    @(negedge link_clk);
    for (int c = 0; c < NUM_CH; c++) begin
      pn_word[c] = pn_word_after(pn_word[c], c >= 2);
      adc_data[c*SAMPLE_W +: SAMPLE_W] =
        zero_mask[c] ? '0 : (pn_word[c] ^ {15'd0, flip_mask[c]});
    end
    adc_valid = 1'b1;
    @(negedge link_clk);
    adc_valid = 1'b0;
  endtask

  // ******************************************************************
  // test sequence
  // ******************************************************************

  initial begin
    logic [31:0]         rnd;
    logic [31:0]         ctrl;
    logic [31:0]         sel;
    logic [NUM_CH-1:0]   exp_en;
    logic [NUM_CH-1:0]   exp_type;
    logic [NUM_CH-1:0]   exp_dfmt;
    logic [NUM_CH-1:0]   exp_sext;
    logic [NUM_CH*4-1:0] exp_sel;
    int                  n;

    host_req   = '0;
    adc_data   = '0;
    adc_valid  = 1'b0;
    adc_dovf   = 1'b0;
    adc_rst    = 1'b1;
    lfsr_state = 32'hd808_4640;
    pn_word[0] = 16'h01a5;
    pn_word[1] = 16'h0c3f;
    pn_word[2] = 16'h4d2b;
    pn_word[3] = 16'h7001;
    repeat (5) @(negedge link_clk);
    adc_rst = 1'b0;

    // state right after reset
    compare_value("enable", 32'h0, 32'(enable));
    compare_value("dfmt_enable", 32'h0, 32'(dfmt_enable));
    compare_value("dfmt_sign_extend", 32'h0, 32'(dfmt_sign_extend));
    compare_value("dfmt_type", 32'h0, 32'(dfmt_type));
    compare_value("pn_seq_sel", 32'h0, 32'(pn_seq_sel));
    compare_value("pn_oos", 32'({NUM_CH{1'b1}}), 32'(pn_oos));
    verify_reg("status", REG_STATUS, 32'h0);
    verify_reg("version", REG_VERSION, CORE_VERSION);
    verify_reg("id", REG_ID, TB_ID);
    verify_reg("unmapped", 12'h0ff, 32'h0);

    // random register contents
    for (int k = 0; k < 3; k++) begin
      rand_bits(32, rnd);
      write_reg(REG_SCRATCH, rnd);
      verify_reg("scratch", REG_SCRATCH, rnd);
    end
    for (int c = 0; c < NUM_CH; c++) begin
      rand_bits(7, ctrl);
      rand_bits(4, sel);
      write_reg(chan_addr(c, CH_CTRL), ctrl);
      write_reg(chan_addr(c, CH_PN_SEL), sel);
      verify_reg($sformatf("ctrl[%0d]", c), chan_addr(c, CH_CTRL), ctrl & 32'h55);
      verify_reg($sformatf("pn_sel[%0d]", c), chan_addr(c, CH_PN_SEL), sel);
      exp_en[c]         = ctrl[0];
      exp_type[c]       = ctrl[2];
      exp_dfmt[c]       = ctrl[4];
      exp_sext[c]       = ctrl[6];
      exp_sel[c*4 +: 4] = sel[3:0];
    end
    compare_value("enable", 32'(exp_en), 32'(enable));
    compare_value("dfmt_type", 32'(exp_type), 32'(dfmt_type));
    compare_value("dfmt_enable", 32'(exp_dfmt), 32'(dfmt_enable));
    compare_value("dfmt_sign_extend", 32'(exp_sext), 32'(dfmt_sign_extend));
    compare_value("pn_seq_sel", 32'(exp_sel), 32'(pn_seq_sel));

    // PN9 on 0 and 1, PN15 on 2 and 3, then release core reset
    for (int c = 0; c < NUM_CH; c++) begin
      write_reg(chan_addr(c, CH_PN_SEL), (c >= 2) ? 32'(PN_MODE_PN15) : 32'(PN_MODE_PN9));
    end
    send_beat('0, '0);
    write_reg(REG_RSTN, 32'h1);
    verify_reg("status", REG_STATUS, 32'h1);
    n = 0;
    while (pn_oos != '0 && n < 40) begin
      send_beat('0, '0);
      n++;
    end
    require_true(pn_oos == '0, "pn_oos did not clear on clean PN streams");
    require_true(n >= PN_SYNC_COUNT, "pn_oos cleared after fewer than 16 samples");
    for (int c = 0; c < NUM_CH; c++) begin
      verify_reg($sformatf("pn_status[%0d]", c), chan_addr(c, CH_PN_STATUS), 32'h0);
    end
    verify_reg("pn_summary", REG_PN_SUM, 32'h0);

    // single bit error on channel 1
    send_beat(4'b0010, '0);
    compare_value("pn_err", 32'h2, 32'(pn_err));
    send_beat('0, '0);
    send_beat('0, '0);
    compare_value("pn_oos", 32'h0, 32'(pn_oos));
    verify_reg("pn_status[1]", chan_addr(1, CH_PN_STATUS), 32'h2);
    verify_reg("pn_summary", REG_PN_SUM, 32'h1);
    write_reg(chan_addr(1, CH_PN_STATUS), 32'h2);
    write_reg(REG_PN_SUM, 32'h1);
    for (int c = 0; c < NUM_CH; c++) begin
      verify_reg($sformatf("pn_status[%0d]", c), chan_addr(c, CH_PN_STATUS), 32'h0);
    end
    verify_reg("pn_summary", REG_PN_SUM, 32'h0);

    // overflow flag holds until written with a one
    @(negedge link_clk);
    adc_dovf = 1'b1;
    @(negedge link_clk);
    adc_dovf = 1'b0;
    verify_reg("overflow", REG_OVF, 32'h1);
    write_reg(REG_OVF, 32'h0);
    verify_reg("overflow", REG_OVF, 32'h1);
    write_reg(REG_OVF, 32'h1);
    verify_reg("overflow", REG_OVF, 32'h0);

    // channel 3 loses sync on zero samples
    n = 0;
    while (!pn_oos[3] && n < 40) begin
      send_beat('0, 4'b1000);
      n++;
    end
    require_true(pn_oos[3], "pn_oos[3] stayed low on non-PN samples");
    compare_value("samples_to_lose_sync", 32'(PN_SYNC_COUNT), 32'(n));
    compare_value("pn_oos", 32'h8, 32'(pn_oos));
    verify_reg("pn_status[3]", chan_addr(3, CH_PN_STATUS), 32'h6);
    verify_reg("pn_summary", REG_PN_SUM, 32'h3);

    // disabled mode forces channel 2 out of sync
    write_reg(chan_addr(2, CH_PN_SEL), 32'hf);
    @(negedge link_clk);
    compare_value("pn_oos", 32'hc, 32'(pn_oos));

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
source/tpl_adc_pkg.sv
source/up_bus_merge.sv
source/up_adc_common_regs.sv
source/up_adc_channel_regs.sv
source/adc_pn_monitor.sv
source/tpl_adc_regmap.sv
test/tpl_adc_regmap_sva.sv
test/tb_tpl_adc_regmap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then look for a failure in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_tpl_adc_regmap \
  -f sim.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
grep -q "TEST FAIL" sim.log \
  && { echo "simulation failed, see sim.log and build.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
